//--- Bender.yml
package:
  name: dcache_sys

sources:
  # synthesizable design, package first
  - target: any(rtl, test)
    files:
      - verilog/dcache_pkg.sv
      - verilog/access_if.sv
      - verilog/mshr.sv
      - verilog/dcache_array.sv
      - verilog/size_align.sv
      - verilog/dcache_top.sv

  # testbench and memory model
  - target: test
    files:
      - bench/mem_model.sv
      - bench/dcache_tb.sv

//--- bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int num_lines  = 16;
    localparam int index_bits = $clog2(num_lines);
    localparam int mem_blocks = 1024;
    localparam int max_wait   = 200;

    typedef struct packed {
        addr_t  addr;
        logic   is_store;
        logic   hit;
        block_t load;
        block_t block;
    } expect_t;

    logic         clock;
    logic         reset;
    logic         valid;
    addr_t        addr;
    block_t       store_data;
    mem_size_e    st_size;
    logic         is_store;
    logic         stall;
    logic         done;
    block_t       load_data;
    mem_command_e proc2mem_command;
    addr_t        proc2mem_addr;
    block_t       proc2mem_data;
    mem_tag_t     mem2proc_transaction_tag;
    mem_tag_t     mem2proc_data_tag;
    block_t       mem2proc_data;
    logic         heavy_refusals;

    // reference memory and cache directory
    block_t               shadow [mem_blocks];
    logic [num_lines-1:0] ref_valid;
    addr_t                ref_tag [num_lines];

    expect_t expect_q [$];
    int      issued;
    int      checked;
    int      errors;

    // bus activity seen during the current access
    int      loads_seen;
    int      stores_seen;
    block_t  store_seen;
    addr_t   store_addr_seen;

    initial clock = 1'b0;
    always #5 clock = ~clock;

    dcache_top #(
        .num_lines (num_lines)
    ) dcache_top_i (
        .clock                    (clock),
        .reset                    (reset),
        .valid                    (valid),
        .addr                     (addr),
        .store_data               (store_data),
        .st_size                  (st_size),
        .is_store                 (is_store),
        .stall                    (stall),
        .done                     (done),
        .load_data                (load_data),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data)
    );

    mem_model mem_model_i (
        .clock                    (clock),
        .reset                    (reset),
        .heavy_refusals           (heavy_refusals),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data)
    );

    // same start pattern as the memory model
    function automatic block_t initial_block(addr_t a);
        return {~a, a ^ 32'h9e37_79b9};
    endfunction

    // expected outcome of one access, updates the reference state
    function automatic expect_t reference_access(addr_t a, block_t data, mem_size_e size,
                                                 logic st);
        expect_t e;
        int      nbytes;
        int      off;
        int      idx;
        int      slot;
        addr_t   tag;
        block_t  blk;
        nbytes = 1 << size;
        off    = int'(a[2:0]);
        idx    = int'((a >> 3) % num_lines);
        tag    = a >> (3 + index_bits);
        slot   = int'(a[12:3]);
        blk    = shadow[slot];
        e.addr     = a;
        e.is_store = st;
        e.hit      = ref_valid[idx] && (ref_tag[idx] == tag);
        if (st) begin
            for (int i = 0; i < nbytes; i++) begin
                blk[8*(off+i) +: 8] = data[8*i +: 8];
            end
        end
        // loads come back zero-extended
        e.load = '0;
        for (int i = 0; i < nbytes; i++) begin
            e.load[8*i +: 8] = blk[8*(off+i) +: 8];
        end
        e.block        = blk;
        shadow[slot]   = blk;
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        return e;
    endfunction

    task automatic stop_with_failure();
        errors++;
        $display("Test failures found");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, want, got);
            stop_with_failure();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("check failed: %s", what);
            stop_with_failure();
        end
    endtask

    task automatic check_idle_outputs();
        check_value("stall", 64'(stall), 64'h0);
        check_value("done", 64'(done), 64'h0);
        check_value("proc2mem_command", 64'(proc2mem_command), 64'(mem_none));
    endtask

    task automatic sample_bus();
        if (proc2mem_command == mem_load) begin
            loads_seen++;
        end
        if (proc2mem_command == mem_store) begin
            stores_seen++;
            store_seen      = proc2mem_data;
            store_addr_seen = proc2mem_addr;
            check_true(!stall || mem2proc_data_tag != '0,
                       "mem_store issued while stalled before the fill");
        end
    endtask

    task automatic run_access(input addr_t a, input block_t data, input mem_size_e size,
                              input logic st);
        int waited;
        @(posedge clock);
        #1;
        waited = 0;
        while (stall) begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > max_wait) begin
                $display("timeout: stall stayed high for %0d cycles", max_wait);
                stop_with_failure();
            end
        end
        valid      = 1'b1;
        addr       = a;
        store_data = data;
        st_size    = size;
        is_store   = st;
        expect_q.push_back(reference_access(a, data, size, st));
        issued++;
        @(posedge clock);
        #1;
        valid  = 1'b0;
        waited = 0;
        while (checked != issued) begin
            @(posedge clock);
            waited++;
            if (waited > max_wait + 10) begin
                $display("timeout: access to 0x%h was never checked", a);
                stop_with_failure();
            end
        end
    endtask

    task automatic random_access(input int span_blocks);
        mem_size_e size;
        addr_t     a;
        block_t    d;
        int        nbytes;
        size   = mem_size_e'($urandom_range(3, 0));
        nbytes = 1 << size;
        a      = addr_t'($urandom_range(span_blocks - 1, 0)) << 3;
        // naturally aligned offset
        a      = a | addr_t'($urandom_range(7, 0) & ~(nbytes - 1));
        d      = {$urandom, $urandom};
        run_access(a, d, size, logic'($urandom_range(1, 0)));
    endtask

    initial begin : check_process
        expect_t e;
        int      waited;
        forever begin
            @(negedge clock);
            if (expect_q.size() != 0) begin
                e           = expect_q.pop_front();
                loads_seen  = 0;
                stores_seen = 0;
                waited      = 0;
                sample_bus();
                while (!done) begin
                    @(negedge clock);
                    waited++;
                    if (waited > max_wait) begin
                        $display("timeout: access to 0x%h not done in %0d cycles",
                                 e.addr, max_wait);
                        stop_with_failure();
                    end
                    sample_bus();
                    // a miss holds stall until the fill completes
                    if (!done) begin
                        check_value("stall", 64'(stall), 64'h1);
                    end
                end
                check_value("stall", 64'(stall), 64'h0);
                // a hit finishes one cycle after acceptance
                check_true((waited == 1) == e.hit, "hit or miss latency differs from model");
                check_true(e.hit ? loads_seen == 0 : loads_seen != 0,
                           "mem_load activity does not match hit or miss");
                if (e.is_store) begin
                    check_value("mem_store count", 64'(stores_seen), 64'h1);
                    check_value("proc2mem_data", store_seen, e.block);
                    check_value("proc2mem_addr", 64'(store_addr_seen),
                                64'({e.addr[31:3], 3'b0}));
                end else begin
                    check_value("mem_store count", 64'(stores_seen), 64'h0);
                    check_value("load_data", load_data, e.load);
                end
                checked++;
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'h261c));
        reset          = 1'b1;
        valid          = 1'b0;
        addr           = '0;
        store_data     = '0;
        st_size        = mem_byte;
        is_store       = 1'b0;
        heavy_refusals = 1'b0;
        issued         = 0;
        checked        = 0;
        errors         = 0;
        ref_valid      = '0;
        for (int i = 0; i < mem_blocks; i++) begin
            shadow[i] = initial_block(addr_t'(i * 8));
        end

        repeat (10) begin
            @(posedge clock);
            #1;
            check_idle_outputs();
        end
        reset = 1'b0;
        repeat (3) begin
            @(negedge clock);
            check_idle_outputs();
        end

        // load miss, then hits on the same block
        run_access(32'h0000_0100, '0, mem_double, 1'b0);
        run_access(32'h0000_0100, '0, mem_double, 1'b0);
        run_access(32'h0000_0104, '0, mem_word, 1'b0);

        // every store size, hits first, then misses
        run_access(32'h0000_0101, 64'h0000_0000_0000_00a5, mem_byte, 1'b1);
        run_access(32'h0000_0106, 64'h0000_0000_0000_beef, mem_half, 1'b1);
        run_access(32'h0000_0114, 64'h0000_0000_1234_5678, mem_word, 1'b1);
        run_access(32'h0000_0118, 64'hfeed_face_cafe_f00d, mem_double, 1'b1);
        run_access(32'h0000_0123, 64'h0000_0000_0000_003c, mem_byte, 1'b1);
        run_access(32'h0000_012a, 64'h0000_0000_0000_7e81, mem_half, 1'b1);
        run_access(32'h0000_0100, '0, mem_double, 1'b0);
        run_access(32'h0000_0110, '0, mem_double, 1'b0);
        run_access(32'h0000_0120, '0, mem_double, 1'b0);
        run_access(32'h0000_0128, '0, mem_half, 1'b0);

        // 0x100 and 0x180 share index 0
        run_access(32'h0000_0180, '0, mem_double, 1'b0);
        run_access(32'h0000_0100, '0, mem_double, 1'b0);
        run_access(32'h0000_0184, 64'h0000_0000_0bad_c0de, mem_word, 1'b1);
        run_access(32'h0000_0106, '0, mem_half, 1'b0);

        // memory refuses most loads
        @(posedge clock);
        #1;
        heavy_refusals = 1'b1;
        repeat (30) begin
            random_access(32);
        end
        @(posedge clock);
        #1;
        heavy_refusals = 1'b0;

        repeat (300) begin
            random_access(128);
        end

        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            stop_with_failure();
        end
        $finish;
    end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     heavy_refusals,
    input  dcache_pkg::mem_command_e proc2mem_command,
    input  dcache_pkg::addr_t        proc2mem_addr,
    input  dcache_pkg::block_t       proc2mem_data,
    output dcache_pkg::mem_tag_t     mem2proc_transaction_tag,
    output dcache_pkg::mem_tag_t     mem2proc_data_tag,
    output dcache_pkg::block_t       mem2proc_data
);
    import dcache_pkg::*;

    // 8 KiB window of backing store
    localparam int window_blocks = 1024;

    block_t   storage [window_blocks];
    logic     refuse;
    mem_tag_t next_tag;
    logic     pending;
    mem_tag_t pending_tag;
    addr_t    pending_addr;
    int       countdown;

    // start value of a block, built from its full address
    function automatic block_t initial_block(addr_t a);
        return {~a, a ^ 32'h9e37_79b9};
    endfunction

    function automatic int slot(addr_t a);
        return int'(a[12:3]);
    endfunction

    initial begin
        for (int i = 0; i < window_blocks; i++) begin
            storage[i] = initial_block(addr_t'(i * 8));
        end
    end

    // tag answers the load in the same cycle, zero when busy
    assign mem2proc_transaction_tag =
        (proc2mem_command == mem_load && !refuse && !pending) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            refuse            <= 1'b0;
            next_tag          <= 4'h1;
            pending           <= 1'b0;
            mem2proc_data_tag <= '0;
            mem2proc_data     <= '0;
        end else begin
            refuse <= heavy_refusals ? ($urandom_range(3, 0) != 0)
                                     : ($urandom_range(3, 0) == 0);
            mem2proc_data_tag <= '0;
            if (mem2proc_transaction_tag != '0) begin
                pending      <= 1'b1;
                pending_tag  <= mem2proc_transaction_tag;
                pending_addr <= proc2mem_addr;
                countdown    <= $urandom_range(9, 2);
                // tags rotate through 1..15
                next_tag     <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
            end else if (pending) begin
                if (countdown <= 1) begin
                    mem2proc_data_tag <= pending_tag;
                    mem2proc_data     <= storage[slot(pending_addr)];
                    pending           <= 1'b0;
                end else begin
                    countdown <= countdown - 1;
                end
            end
            if (proc2mem_command == mem_store) begin
                storage[slot(proc2mem_addr)] <= proc2mem_data;
            end
        end
    end

endmodule

//--- dcache_sys.f
verilog/dcache_pkg.sv
verilog/access_if.sv
verilog/mshr.sv
verilog/dcache_array.sv
verilog/size_align.sv
verilog/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

//--- verilog/access_if.sv
`timescale 1ns/1ps

interface access_if;
    import dcache_pkg::*;

    // one access finishing this cycle
    logic      complete;
    // line came back from memory
    logic      fill;
    addr_t     addr;
    // base block before any store merge
    block_t    line;
    mem_size_e st_size;
    logic      is_store;
    block_t    store_data;

    modport mshr (
        output complete, fill, addr, line, st_size, is_store, store_data
    );

    modport datapath (
        input complete, fill, addr, line, st_size, is_store, store_data
    );

endinterface

//--- verilog/dcache_array.sv
`timescale 1ns/1ps

module dcache_array #(
    parameter int num_lines = 16
) (
    input  logic               clock,
    input  logic               reset,
    input  dcache_pkg::addr_t  lookup_addr,
    input  dcache_pkg::block_t merged_line,
    access_if.datapath         acc,
    output logic               hit,
    output dcache_pkg::block_t hit_line
);
    import dcache_pkg::*;

    localparam int index_bits = $clog2(num_lines);
    localparam int tag_lsb    = index_bits + block_offset_bits;
    localparam int tag_bits   = $bits(addr_t) - tag_lsb;

    logic [num_lines-1:0] line_valid;
    logic [tag_bits-1:0]  tags  [num_lines];
    block_t               lines [num_lines];

    logic [index_bits-1:0] rd_index;
    logic [tag_bits-1:0]   rd_tag;
    logic [index_bits-1:0] wr_index;
    logic [tag_bits-1:0]   wr_tag;
    logic                  write_en;

    // lookup side, processor address
    assign rd_index = lookup_addr[tag_lsb-1:block_offset_bits];
    assign rd_tag   = lookup_addr[$bits(addr_t)-1:tag_lsb];

    // write side, address of the completing access
    assign wr_index = acc.addr[tag_lsb-1:block_offset_bits];
    assign wr_tag   = acc.addr[$bits(addr_t)-1:tag_lsb];

    // fills and stores both land in the array
    assign write_en = acc.complete && (acc.fill || acc.is_store);

    assign hit      = line_valid[rd_index] && (tags[rd_index] == rd_tag);
    assign hit_line = lines[rd_index];

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (write_en) begin
            line_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            tags[wr_index]  <= wr_tag;
            lines[wr_index] <= merged_line;
        end
    end

    // the mshr must hand over a clean address with every write
    assert property (@(posedge clock) disable iff (reset)
        write_en |-> !$isunknown(acc.addr));

endmodule

//--- verilog/dcache_pkg.sv
package dcache_pkg;

    // byte address and block geometry
    typedef logic [31:0] addr_t;
    typedef logic [63:0] block_t;

    // byte offset inside one 8-byte block
    localparam int block_offset_bits = 3;

    // memory transaction tag, zero means no transaction
    typedef logic [3:0] mem_tag_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        mem_byte   = 2'h0,
        mem_half   = 2'h1,
        mem_word   = 2'h2,
        mem_double = 2'h3
    } mem_size_e;

    // command toward the memory bus
    typedef enum logic [1:0] {
        mem_none  = 2'h0,
        mem_load  = 2'h1,
        mem_store = 2'h2
    } mem_command_e;

    // single miss entry
    // retry means memory refused the load with tag zero
    typedef enum logic [1:0] {
        idle      = 2'h0,
        retry     = 2'h1,
        wait_data = 2'h2
    } mshr_state_e;

endpackage

//--- verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int num_lines = 16
) (
    input  logic                     clock,
    input  logic                     reset,

    // load/store unit
    input  logic                     valid,
    input  dcache_pkg::addr_t        addr,
    input  dcache_pkg::block_t       store_data,
    input  dcache_pkg::mem_size_e    st_size,
    input  logic                     is_store,
    output logic                     stall,
    output logic                     done,
    output dcache_pkg::block_t       load_data,

    // memory bus
    output dcache_pkg::mem_command_e proc2mem_command,
    output dcache_pkg::addr_t        proc2mem_addr,
    output dcache_pkg::block_t       proc2mem_data,
    input  dcache_pkg::mem_tag_t     mem2proc_transaction_tag,
    input  dcache_pkg::mem_tag_t     mem2proc_data_tag,
    input  dcache_pkg::block_t       mem2proc_data
);
    import dcache_pkg::*;

    logic   hit;
    block_t hit_line;
    // store-merged block, also the write-through data
    block_t merged_line;

    access_if acc ();

    mshr mshr_i (
        .clock                    (clock),
        .reset                    (reset),
        .valid                    (valid),
        .addr                     (addr),
        .store_data               (store_data),
        .st_size                  (st_size),
        .is_store                 (is_store),
        .hit                      (hit),
        .hit_line                 (hit_line),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .stall                    (stall),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .acc                      (acc.mshr)
    );

    dcache_array #(
        .num_lines (num_lines)
    ) dcache_array_i (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (addr),
        .merged_line (merged_line),
        .acc         (acc.datapath),
        .hit         (hit),
        .hit_line    (hit_line)
    );

    size_align size_align_i (
        .clock       (clock),
        .reset       (reset),
        .acc         (acc.datapath),
        .merged_line (merged_line),
        .done        (done),
        .load_data   (load_data)
    );

    assign proc2mem_data = merged_line;

endmodule

//--- verilog/mshr.sv
`timescale 1ns/1ps

module mshr (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    valid,
    input  dcache_pkg::addr_t       addr,
    input  dcache_pkg::block_t      store_data,
    input  dcache_pkg::mem_size_e   st_size,
    input  logic                    is_store,
    input  logic                    hit,
    input  dcache_pkg::block_t      hit_line,
    input  dcache_pkg::mem_tag_t    mem2proc_transaction_tag,
    input  dcache_pkg::mem_tag_t    mem2proc_data_tag,
    input  dcache_pkg::block_t      mem2proc_data,
    output logic                    stall,
    output dcache_pkg::mem_command_e proc2mem_command,
    output dcache_pkg::addr_t       proc2mem_addr,
    access_if.mshr                  acc
);
    import dcache_pkg::*;

    mshr_state_e state, next_state;
    mem_tag_t    saved_tag, next_tag;
    logic        capture;
    logic        accept;

    // parked request
    addr_t       saved_addr;
    block_t      saved_data;
    mem_size_e   saved_size;
    logic        saved_store;

    function automatic addr_t block_base(addr_t a);
        addr_t base;
        base = a;
        base[block_offset_bits-1:0] = '0;
        return base;
    endfunction

    assign stall  = (state != idle);
    assign accept = valid && !stall;

    always_comb begin
        next_state       = state;
        next_tag         = saved_tag;
        capture          = 1'b0;
        proc2mem_command = mem_none;
        proc2mem_addr    = block_base(addr);

        acc.complete   = 1'b0;
        acc.fill       = 1'b0;
        acc.addr       = addr;
        acc.line       = hit_line;
        acc.st_size    = st_size;
        acc.is_store   = is_store;
        acc.store_data = store_data;

        case (state)
            idle: begin
                if (accept && hit) begin
                    acc.complete = 1'b1;
                    // write through on a store hit
                    if (is_store) begin
                        proc2mem_command = mem_store;
                    end
                end else if (accept) begin
                    proc2mem_command = mem_load;
                    capture          = 1'b1;
                    next_tag         = mem2proc_transaction_tag;
                    next_state = (mem2proc_transaction_tag != '0) ? wait_data : retry;
                end
            end
            retry: begin
                // memory was busy, ask again
                proc2mem_command = mem_load;
                proc2mem_addr    = block_base(saved_addr);
                if (mem2proc_transaction_tag != '0) begin
                    next_tag   = mem2proc_transaction_tag;
                    next_state = wait_data;
                end
            end
            wait_data: begin
                acc.addr       = saved_addr;
                acc.line       = mem2proc_data;
                acc.st_size    = saved_size;
                acc.is_store   = saved_store;
                acc.store_data = saved_data;
                proc2mem_addr  = block_base(saved_addr);
                if (mem2proc_data_tag == saved_tag) begin
                    acc.complete = 1'b1;
                    acc.fill     = 1'b1;
                    if (saved_store) begin
                        proc2mem_command = mem_store;
                    end
                    next_tag   = '0;
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= idle;
            saved_tag <= '0;
        end else begin
            state     <= next_state;
            saved_tag <= next_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            saved_addr  <= addr;
            saved_data  <= store_data;
            saved_size  <= st_size;
            saved_store <= is_store;
        end
    end

    // a zero tag would match an idle data bus
    assert property (@(posedge clock) disable iff (reset)
        state == wait_data |-> saved_tag != '0);

    // no write through before the fill arrives
    assert property (@(posedge clock) disable iff (reset)
        state == retry |-> proc2mem_command != mem_store);

endmodule

//--- verilog/size_align.sv
`timescale 1ns/1ps

module size_align (
    input  logic               clock,
    input  logic               reset,
    access_if.datapath         acc,
    output dcache_pkg::block_t merged_line,
    output logic               done,
    output dcache_pkg::block_t load_data
);
    import dcache_pkg::*;

    logic [block_offset_bits-1:0] offset;
    logic [block_offset_bits-1:0] align_bits;
    logic [7:0]                   size_bytes;
    logic [7:0]                   byte_sel;
    block_t                       size_mask;
    block_t                       store_mask;
    block_t                       shifted_store;
    block_t                       load_value;

    // one bit per byte to a full bit mask
    function automatic block_t expand_bytes(logic [7:0] bytes);
        block_t mask;
        for (int i = 0; i < 8; i++) begin
            mask[8*i +: 8] = {8{bytes[i]}};
        end
        return mask;
    endfunction

    assign offset = acc.addr[block_offset_bits-1:0];

    always_comb begin
        case (acc.st_size)
            mem_byte: size_bytes = 8'h01;
            mem_half: size_bytes = 8'h03;
            mem_word: size_bytes = 8'h0f;
            default:  size_bytes = 8'hff;
        endcase
        // low offset bits that must be zero for this size
        align_bits = block_offset_bits'((1 << acc.st_size) - 1);
    end

    assign byte_sel      = size_bytes << offset;
    assign size_mask     = expand_bytes(size_bytes);
    assign store_mask    = expand_bytes(byte_sel);
    assign shifted_store = acc.store_data << {offset, 3'b000};
    assign load_value    = (acc.line >> {offset, 3'b000}) & size_mask;

    assign merged_line = acc.is_store ?
        ((acc.line & ~store_mask) | (shifted_store & store_mask)) : acc.line;

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= acc.complete;
        end
    end

    always_ff @(posedge clock) begin
        if (acc.complete && !acc.is_store) begin
            load_data <= load_value;
        end
    end

    // a misaligned access would spill into the next block
    assert property (@(posedge clock) disable iff (reset)
        acc.complete |-> (offset & align_bits) == '0);

endmodule
